/* vlog.f */
fb_pkg.sv
fb_write_if.sv
cmd_byte_fifo.sv
cmd_write_pixel.sv
cmd_fill_row.sv
cmd_dispatch.sv
framebuffer_ram.sv
display_ctrl_top.sv
tb_display_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the display controller testbench with Verilator, runs it and scans the log
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_display_ctrl -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    && ! grep -q "TEST RESULT: FAIL" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb_display_ctrl.sv */
// Testbench for the display controller with a credit-obeying host and a reference framebuffer
// Runs directed and random commands, then reads the framebuffer back through the rd_* port
`timescale 1ns/1ns

module tb_display_ctrl;
    import fb_pkg::*;

    localparam int BYTES_PER_PIXEL = 3;
    localparam int NUM_ROWS        = 16;
    localparam int NUM_COLS        = 20;
    localparam int FIFO_DEPTH      = 8;
    // Every command may cost a row fill plus slow bytes; every byte read back costs two cycles
    localparam int NUM_CMDS   = NUM_ROWS + 50;
    localparam int CMD_CYCLES = NUM_COLS * BYTES_PER_PIXEL + 8 * 4;
    localparam int MAX_CYCLES = 2 * (NUM_CMDS * CMD_CYCLES
                                     + 4 * 2 * NUM_ROWS * NUM_COLS * BYTES_PER_PIXEL);

    logic         clk;
    logic         reset;
    logic [7:0]   rx_data;
    logic         rx_valid;
    logic         credit_return;
    logic         cmd_done;
    row_addr_t    rd_row;
    col_addr_t    rd_col;
    color_index_t rd_pixel;
    logic [7:0]   rd_data;

    logic [7:0]  ref_mem [NUM_ROWS][NUM_COLS][BYTES_PER_PIXEL];
    logic [31:0] rng = 32'h3b9a;
    int          credits = FIFO_DEPTH;       // Host view of free buffer slots
    int          min_credits = FIFO_DEPTH;
    int          done_count = 0;
    int          expected_done = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    display_ctrl_top #(
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL),
        .NUM_ROWS        (NUM_ROWS),
        .NUM_COLS        (NUM_COLS),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) dut0 (
        .clk           (clk),
        .reset         (reset),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .credit_return (credit_return),
        .cmd_done      (cmd_done),
        .rd_row        (rd_row),
        .rd_col        (rd_col),
        .rd_pixel      (rd_pixel),
        .rd_data       (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    function automatic int pick_gap(input int max_gap);
        return (max_gap > 0) ? rand_below(max_gap + 1) : 0;
    endfunction

    function automatic void ref_write(input int r, input int c, input int p, input logic [7:0] b);
        if (r < NUM_ROWS && c < NUM_COLS && p < BYTES_PER_PIXEL) begin
            ref_mem[r][c][p] = b;                // Writes outside the array are dropped
        end
    endfunction

    function automatic logic [7:0] ref_byte(input int r, input int c, input int p);
        if (r >= NUM_ROWS || c >= NUM_COLS || p >= BYTES_PER_PIXEL) begin
            return 8'h00;
        end
        return ref_mem[r][c][p];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Host model
    ////////////////////////////////////////////////////////////////////////////

    // Credits are spent when a byte is seen at negedge and returned with each credit_return
    always @(negedge clk) begin
        if (!reset) begin
            credits = credits - int'(rx_valid) + int'(credit_return);
            if (credits < min_credits) begin
                min_credits = credits;
            end
            assert (credits <= FIFO_DEPTH) else begin
                errors++;
                $display("FAIL credit count: got %h, limit %h", credits, FIFO_DEPTH);
            end
            if (cmd_done) begin
                done_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic send_byte(input logic [7:0] b, input int gap);
        repeat (gap) begin
            @(posedge clk);
            #2 rx_valid = 1'b0;
        end
        do begin
            @(posedge clk);
            #2 rx_valid = 1'b0;
        end while (credits == 0);                // Stall until a credit comes back
        rx_data  = b;
        rx_valid = 1'b1;
    endtask

    task automatic write_pixel(input int r, input int c, input logic [31:0] pix, input int gap);
        send_byte(OP_WRITE_PIXEL, pick_gap(gap));
        send_byte(8'(r), pick_gap(gap));
        send_byte(8'(c), pick_gap(gap));         // Column low byte first
        send_byte(8'(c >> 8), pick_gap(gap));
        for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
            send_byte(pix[8*k +: 8], pick_gap(gap));
            ref_write(r, c, BYTES_PER_PIXEL - 1 - k, pix[8*k +: 8]);
        end
        expected_done++;
    endtask

    task automatic fill_row(input int r, input logic [31:0] color, input int gap);
        send_byte(OP_FILL_ROW, pick_gap(gap));
        send_byte(8'(r), pick_gap(gap));
        for (int k = 0; k < BYTES_PER_PIXEL; k++) begin
            send_byte(color[8*k +: 8], pick_gap(gap));
            for (int c = 0; c < NUM_COLS; c++) begin
                ref_write(r, c, BYTES_PER_PIXEL - 1 - k, color[8*k +: 8]);
            end
        end
        expected_done++;
    endtask

    // Idle means every credit is home and every command has signalled done
    task automatic wait_idle();
        @(posedge clk);
        #2 rx_valid = 1'b0;
        while (credits != FIFO_DEPTH || done_count < expected_done) begin
            @(posedge clk);
        end
        repeat (5) @(posedge clk);
        assert (done_count == expected_done) else begin
            errors++;
            $display("FAIL cmd_done pulses: got %h, expected %h", done_count, expected_done);
        end
        assert (credits == FIFO_DEPTH) else begin
            errors++;
            $display("FAIL host credits: got %h, expected %h", credits, FIFO_DEPTH);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Read-back checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_byte(input int r, input int c, input int p);
        logic [7:0] exp;
        @(posedge clk);
        #2;
        rd_row   = row_addr_t'(r);
        rd_col   = col_addr_t'(c);
        rd_pixel = color_index_t'(p);
        @(posedge clk);
        @(negedge clk);                          // rd_data settled one edge after the address
        exp = ref_byte(r, c, p);
        checks++;
        assert (rd_data == exp) else begin
            errors++;
            $display("FAIL rd_data row %h col %h pixel %h: got %h, expected %h",
                     r, c, p, rd_data, exp);
        end
    endtask

    task automatic check_row(input int r);
        for (int c = 0; c < NUM_COLS; c++) begin
            for (int p = 0; p < BYTES_PER_PIXEL; p++) begin
                check_byte(r, c, p);
            end
        end
    endtask

    task automatic check_all();
        for (int r = 0; r < NUM_ROWS; r++) begin
            check_row(r);
        end
    endtask

    initial begin
        reset    = 1'b1;
        rx_data  = 8'h00;
        rx_valid = 1'b0;
        rd_row   = '0;
        rd_col   = '0;
        rd_pixel = '0;
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        repeat (10) begin                        // Quiet outputs while nothing is sent
            @(negedge clk);
            assert (credit_return == 1'b0) else begin
                errors++;
                $display("FAIL credit_return: got %h, expected %h", credit_return, 1'b0);
            end
            assert (cmd_done == 1'b0) else begin
                errors++;
                $display("FAIL cmd_done: got %h, expected %h", cmd_done, 1'b0);
            end
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            fill_row(r, 32'(r) * 32'h00010203 + 32'h00405060, 0);  // Known contents everywhere
        end
        wait_idle();
        check_all();
        // Column 263 lies outside the array, so row 5 must keep its fill
        write_pixel(5, 256 + 7, 32'h00c3b2a1, 0);
        write_pixel(6, 7, 32'h00f00d55, 1);
        wait_idle();
        check_row(5);
        check_row(6);
        for (int p = 0; p < BYTES_PER_PIXEL; p++) begin
            check_byte(5, 256 + 7, p);
        end
        // A fill followed by a burst fills the buffer and stalls the host
        min_credits = FIFO_DEPTH;
        fill_row(9, 32'h0077aa33, 0);
        write_pixel(10, 3, 32'h00123456, 0);
        send_byte(OP_NOP, 0);
        wait_idle();
        assert (min_credits == 0) else begin
            $display("Host was never stalled by the row fill");
            errors++;
        end
        check_all();
        send_byte(OP_NOP, 0);
        send_byte(8'h7f, 0);                     // Unknown opcode
        write_pixel(12, NUM_COLS - 1, 32'h00e1d2c3, 0);
        wait_idle();
        check_row(12);
        repeat (40) begin
            if (rand_below(2) == 0) begin
                fill_row(rand_below(NUM_ROWS), next_rand(), 2);
            end else begin
                write_pixel(rand_below(NUM_ROWS), rand_below(NUM_COLS), next_rand(), 2);
            end
        end
        wait_idle();
        check_all();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* display_ctrl_top.sv */
// Top level of the display controller command path with plain host and read-back ports
// The host sends bytes against credits; a scan-out engine reads pixels through rd_*
`timescale 1ns/1ns

module display_ctrl_top #(
    parameter int BYTES_PER_PIXEL = 3,
    parameter int NUM_ROWS        = 16,
    parameter int NUM_COLS        = 20,
    parameter int FIFO_DEPTH      = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           rx_data,
    input  logic                 rx_valid,
    output logic                 credit_return,
    output logic                 cmd_done,
    input  fb_pkg::row_addr_t    rd_row,
    input  fb_pkg::col_addr_t    rd_col,
    input  fb_pkg::color_index_t rd_pixel,
    output logic [7:0]           rd_data
);
    import fb_pkg::*;

    logic [7:0] fifo_byte;
    logic       fifo_not_empty;
    logic       fifo_pop;
    fb_addr_t   rd_addr;

    fb_write_if fb_bus ();

    assign rd_addr  = '{row: rd_row, col: rd_col, pixel: rd_pixel};
    assign cmd_done = fb_bus.done;                 // Pulses with the last write of a command

    cmd_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk           (clk),
        .reset         (reset),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .pop           (fifo_pop),
        .byte_out      (fifo_byte),
        .not_empty     (fifo_not_empty),
        .credit_return (credit_return)
    );

    cmd_dispatch #(
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL),
        .NUM_COLS        (NUM_COLS)
    ) u_dispatch (
        .clk       (clk),
        .reset     (reset),
        .byte_in   (fifo_byte),
        .not_empty (fifo_not_empty),
        .pop       (fifo_pop),
        .fb        (fb_bus.source)
    );

    framebuffer_ram #(
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL),
        .NUM_ROWS        (NUM_ROWS),
        .NUM_COLS        (NUM_COLS)
    ) u_ram (
        .clk     (clk),
        .fb      (fb_bus.sink),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* framebuffer_ram.sv */
// Byte-wide framebuffer memory with one write port and one registered read port
// Out-of-range writes are ignored and out-of-range reads return zero
`timescale 1ns/1ns

module framebuffer_ram #(
    parameter int BYTES_PER_PIXEL = 3,
    parameter int NUM_ROWS        = 16,
    parameter int NUM_COLS        = 20
) (
    input  logic             clk,
    fb_write_if.sink         fb,
    input  fb_pkg::fb_addr_t rd_addr,
    output logic [7:0]       rd_data
);
    import fb_pkg::*;

    localparam int DEPTH = NUM_ROWS * NUM_COLS * BYTES_PER_PIXEL;

    logic [7:0] mem [DEPTH];

    function automatic logic in_range(input fb_addr_t a);
        return (int'(a.row) < NUM_ROWS) && (int'(a.col) < NUM_COLS) &&
               (int'(a.pixel) < BYTES_PER_PIXEL);
    endfunction

    // Row-major layout with the pixel bytes of one column side by side
    function automatic int lin_index(input fb_addr_t a);
        return (int'(a.row) * NUM_COLS + int'(a.col)) * BYTES_PER_PIXEL + int'(a.pixel);
    endfunction

    always_ff @(posedge clk) begin
        if (fb.wr_en && in_range(fb.addr)) begin
            mem[lin_index(fb.addr)] <= fb.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (in_range(rd_addr)) begin
            rd_data <= mem[lin_index(rd_addr)];
        end else begin
            rd_data <= 8'h00;
        end
    end

endmodule

/* cmd_dispatch.sv */
// Opcode decoder that routes payload bytes to the write-pixel and fill-row handlers
// The active handler's write requests are forwarded unregistered onto fb
`timescale 1ns/1ns

module cmd_dispatch #(
    parameter int BYTES_PER_PIXEL = 3,
    parameter int NUM_COLS        = 20
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] byte_in,
    input  logic       not_empty,
    output logic       pop,
    fb_write_if.source fb
);
    import fb_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_PIXEL,
        FILL_ROW
    } state_t;

    state_t  state;
    opcode_t opcode;
    logic    wp_ready;
    logic    fr_ready;
    logic    wp_valid;
    logic    fr_valid;
    logic    sel_ready;
    logic    sel_done;

    fb_write_if wp_fb ();
    fb_write_if fr_fb ();

    cmd_write_pixel #(
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL)
    ) u_write_pixel (
        .clk          (clk),
        .reset        (reset),
        .payload_byte (byte_in),
        .byte_valid   (wp_valid),
        .ready        (wp_ready),
        .fb           (wp_fb.source)
    );

    cmd_fill_row #(
        .BYTES_PER_PIXEL (BYTES_PER_PIXEL),
        .NUM_COLS        (NUM_COLS)
    ) u_fill_row (
        .clk          (clk),
        .reset        (reset),
        .payload_byte (byte_in),
        .byte_valid   (fr_valid),
        .ready        (fr_ready),
        .fb           (fr_fb.source)
    );

    assign opcode = opcode_t'(byte_in);

    // The cycle carrying done holds off the next byte, which belongs to a new command
    assign pop      = not_empty && ((state == IDLE) || (sel_ready && !sel_done));
    assign wp_valid = pop && (state == WRITE_PIXEL);
    assign fr_valid = pop && (state == FILL_ROW);

    ////////////////////////////////////////////////////////////////////////////
    // Write bus multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        fb.addr   = '0;
        fb.wdata  = 8'h00;
        fb.wr_en  = 1'b0;
        fb.done   = 1'b0;
        sel_ready = 1'b1;
        sel_done  = 1'b0;
        case (state)
            WRITE_PIXEL: begin
                fb.addr   = wp_fb.addr;
                fb.wdata  = wp_fb.wdata;
                fb.wr_en  = wp_fb.wr_en;
                fb.done   = wp_fb.done;
                sel_ready = wp_ready;
                sel_done  = wp_fb.done;
            end
            FILL_ROW: begin
                fb.addr   = fr_fb.addr;
                fb.wdata  = fr_fb.wdata;
                fb.wr_en  = fr_fb.wr_en;
                fb.done   = fr_fb.done;
                sel_ready = fr_ready;
                sel_done  = fr_fb.done;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        case (opcode)
                            OP_WRITE_PIXEL: state <= WRITE_PIXEL;
                            OP_FILL_ROW:    state <= FILL_ROW;
                            default:        state <= IDLE;   // NOP and unknown bytes vanish
                        endcase
                    end
                end
                WRITE_PIXEL, FILL_ROW: begin
                    if (sel_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* cmd_fill_row.sv */
// Fill-row command handler that paints one colour across every column of a row
// It stalls the byte stream while the row is being written
`timescale 1ns/1ns

module cmd_fill_row #(
    parameter int BYTES_PER_PIXEL = 3,
    parameter int NUM_COLS        = 20
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] payload_byte,
    input  logic       byte_valid,
    output logic       ready,
    fb_write_if.source fb
);
    import fb_pkg::*;

    typedef enum logic [1:0] {
        ROW,
        COLOR,
        FILL
    } state_t;

    state_t       state;
    row_addr_t    cur_row;
    logic [7:0]   color [BYTES_PER_PIXEL];
    color_index_t color_idx;                 // Next colour byte to store
    col_addr_t    cur_col;
    color_index_t pix_idx;

    assign ready = (state != FILL);

    always_ff @(posedge clk) begin
        if (state == FILL) begin
            fb.addr  <= '{row: cur_row, col: cur_col, pixel: pix_idx};
            fb.wdata <= color[pix_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ROW;
            fb.wr_en <= 1'b0;
            fb.done  <= 1'b0;
        end else begin
            fb.wr_en <= 1'b0;
            fb.done  <= 1'b0;
            case (state)
                ROW: begin
                    if (byte_valid) begin
                        cur_row   <= row_addr_t'(payload_byte);
                        color_idx <= color_index_t'(BYTES_PER_PIXEL - 1);
                        state     <= COLOR;
                    end
                end
                COLOR: begin
                    if (byte_valid) begin
                        color[color_idx] <= payload_byte;  // Same byte order as write-pixel
                        if (color_idx == '0) begin
                            cur_col <= '0;
                            pix_idx <= color_index_t'(BYTES_PER_PIXEL - 1);
                            state   <= FILL;
                        end else begin
                            color_idx <= color_idx - 1'b1;
                        end
                    end
                end
                FILL: begin
                    fb.wr_en <= 1'b1;
                    if (pix_idx != '0) begin
                        pix_idx <= pix_idx - 1'b1;
                    end else if (cur_col == col_addr_t'(NUM_COLS - 1)) begin
                        fb.done <= 1'b1;                   // Last byte of the last column
                        state   <= ROW;
                    end else begin
                        cur_col <= cur_col + 1'b1;
                        pix_idx <= color_index_t'(BYTES_PER_PIXEL - 1);
                    end
                end
                default: state <= ROW;
            endcase
        end
    end

endmodule

/* cmd_write_pixel.sv */
// Write-pixel command handler that takes a row, a little-endian column and the pixel bytes
// Every pixel byte becomes one framebuffer write, highest byte index first
`timescale 1ns/1ns

module cmd_write_pixel #(
    parameter int BYTES_PER_PIXEL = 3
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] payload_byte,
    input  logic       byte_valid,
    output logic       ready,
    fb_write_if.source fb
);
    import fb_pkg::*;

    typedef enum logic [1:0] {
        ROW,
        COLUMN,
        PIXEL_BYTES
    } state_t;

    state_t       state;
    row_addr_t    cur_row;
    col_addr_t    cur_col;
    logic         col_byte;                // Set once the low column byte is in
    color_index_t pix_idx;

    assign ready = 1'b1;                   // Every byte is taken as it arrives

    // Address and data of the write
    always_ff @(posedge clk) begin
        if (byte_valid && (state == PIXEL_BYTES)) begin
            fb.addr  <= '{row: cur_row, col: cur_col, pixel: pix_idx};
            fb.wdata <= payload_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ROW;
            col_byte <= 1'b0;
            fb.wr_en <= 1'b0;
            fb.done  <= 1'b0;
        end else begin
            fb.wr_en <= 1'b0;
            fb.done  <= 1'b0;
            if (byte_valid) begin
                case (state)
                    ROW: begin
                        cur_row  <= row_addr_t'(payload_byte);
                        col_byte <= 1'b0;
                        state    <= COLUMN;
                    end
                    COLUMN: begin
                        if (!col_byte) begin
                            cur_col[7:0] <= payload_byte;  // Low byte comes first
                            col_byte     <= 1'b1;
                        end else begin
                            cur_col[8] <= payload_byte[0];
                            pix_idx    <= color_index_t'(BYTES_PER_PIXEL - 1);
                            state      <= PIXEL_BYTES;
                        end
                    end
                    PIXEL_BYTES: begin
                        fb.wr_en <= 1'b1;
                        if (pix_idx == '0) begin
                            fb.done <= 1'b1;               // Final byte of the pixel
                            state   <= ROW;
                        end else begin
                            pix_idx <= pix_idx - 1'b1;
                        end
                    end
                    default: state <= ROW;
                endcase
            end
        end
    end

endmodule

/* cmd_byte_fifo.sv */
// Input byte buffer between the host and the command dispatcher
// Each popped byte returns one credit to the host on the following cycle
`timescale 1ns/1ns

module cmd_byte_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       pop,
    output logic [7:0] byte_out,
    output logic       not_empty,
    output logic       credit_return
);
    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [7:0]    mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          take;

    assign push = rx_valid && (count != CW'(FIFO_DEPTH));  // Full buffer drops the byte
    assign take = pop && not_empty;

    assign byte_out  = mem[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= take;                         // One credit per consumed byte
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* fb_write_if.sv */
// Framebuffer write request bus from the command handlers to the RAM
// A write happens on every edge with wr_en high; done marks a command's final write
`timescale 1ns/1ns

interface fb_write_if;
    import fb_pkg::*;

    fb_addr_t   addr;                    // Row, column and pixel byte
    logic [7:0] wdata;
    logic       wr_en;                   // One write per cycle while high
    logic       done;                    // High with the last write of a command

    // Handlers and the dispatcher output side drive the bus
    modport source (
        output addr, wdata, wr_en, done
    );

    // The RAM and the dispatcher handler side receive it
    modport sink (
        input addr, wdata, wr_en, done
    );

endinterface

/* fb_pkg.sv */
// Shared framebuffer address types and command opcodes for the display controller
// Modules import this package inside their bodies and use scoped names in their headers
package fb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Address fields
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] row_addr_t;      // Up to 256 rows
    typedef logic [8:0] col_addr_t;      // Up to 512 columns, sent as two bytes
    typedef logic [1:0] color_index_t;   // Byte index within one pixel

    // One byte of the framebuffer is named by row, column and pixel byte
    typedef struct packed {
        row_addr_t    row;
        col_addr_t    col;
        color_index_t pixel;
    } fb_addr_t;                         // 19 bits in all

    ////////////////////////////////////////////////////////////////////////////
    // Command opcodes
    ////////////////////////////////////////////////////////////////////////////

    // First byte of every command in the host stream
    typedef enum logic [7:0] {
        OP_NOP         = 8'h00,
        OP_WRITE_PIXEL = 8'h01,          // Row, column low, column high, pixel bytes
        OP_FILL_ROW    = 8'h02           // Row, colour bytes
    } opcode_t;

endpackage
